//--- source/mspe_pkg.sv
`default_nettype none

package mspe_pkg;

    localparam int NUM_CORES       = 4;
    localparam int LINE_W          = 512;
    localparam int INSN_W          = 32;
    localparam int PROG_DEPTH      = 16;
    localparam int TUPLE_W         = 64;
    localparam int TUPLES_PER_LINE = 8;
    localparam int TUPLES_PER_CORE = 2;
    localparam int DATA_W          = 32;
    localparam int NUM_REGS        = 4;

    localparam int PC_W   = $clog2(PROG_DEPTH);
    localparam int BEAT_W = $clog2(TUPLES_PER_LINE);
    localparam int CORE_W = $clog2(NUM_CORES);
    localparam int REG_W  = $clog2(NUM_REGS);
    localparam int OPC_W  = 4;
    localparam int IMM_W  = 16;

    localparam logic [63:0] PROG_ADDR = 64'h0000_0000_0000_1000;

    localparam logic [OPC_W-1:0] OP_NOP  = 4'd0;
    localparam logic [OPC_W-1:0] OP_ADD  = 4'd1;
    localparam logic [OPC_W-1:0] OP_SUB  = 4'd2;
    localparam logic [OPC_W-1:0] OP_ADDI = 4'd3;
    localparam logic [OPC_W-1:0] OP_EMIT = 4'd4;
    localparam logic [OPC_W-1:0] OP_HALT = 4'd5;

    // Register form carries a second source register
    typedef struct packed {
        logic [OPC_W-1:0] opcode;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs;
        logic [23:0]      unused;
    } insn_reg_t;

    // Immediate form carries a 16-bit signed constant in the low half
    typedef struct packed {
        logic [OPC_W-1:0] opcode;
        logic [REG_W-1:0] rd;
        logic [9:0]       unused;
        logic [IMM_W-1:0] imm;
    } insn_imm_t;

    typedef union packed {
        insn_reg_t r;
        insn_imm_t i;
    } insn_t;

endpackage

`default_nettype wire

//--- source/mspe_prog_loader.sv
`timescale 1ns/1ps
`default_nettype none

module mspe_prog_loader (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             all_core_reset,
    input  wire logic                             m0_waitrequest,
    input  wire logic [mspe_pkg::LINE_W-1:0]      m0_readdata,
    input  wire logic                             m0_readdatavalid,
    output logic      [63:0]                      m0_address,
    output logic                                  m0_read,
    output logic                                  prog_we,
    output logic      [mspe_pkg::LINE_W-1:0]      prog_line,
    output logic                                  prog_ready
);

    typedef enum logic [1:0] {
        ST_REQ,
        ST_WAIT,
        ST_LOADED
    } state_t;

    state_t state;

    assign m0_address = mspe_pkg::PROG_ADDR;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_REQ;
            m0_read    <= 1'b0;
            prog_we    <= 1'b0;
            prog_ready <= 1'b0;
        end else if (all_core_reset) begin
            state      <= ST_REQ;
            m0_read    <= 1'b0;
            prog_we    <= 1'b0;
            prog_ready <= 1'b0;
        end else begin
            prog_we <= 1'b0;
            case (state)
                ST_REQ: begin
                    if (!m0_read) begin
                        m0_read <= 1'b1;
                    end else if (!m0_waitrequest) begin
                        m0_read <= 1'b0; // Request accepted this cycle
                        state   <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (m0_readdatavalid) begin
                        prog_we    <= 1'b1;
                        prog_ready <= 1'b1;
                        state      <= ST_LOADED;
                    end
                end
                default: begin
                    state <= ST_LOADED;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WAIT && m0_readdatavalid) begin
            prog_line <= m0_readdata;
        end
    end

endmodule

`default_nettype wire

//--- source/mspe_tuple_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module mspe_tuple_dispatch (
    input  wire logic                                                   clk,
    input  wire logic                                                   rst_n,
    input  wire logic                                                   all_core_reset,
    input  wire logic                                                   prog_ready,
    input  wire logic                                                   recv_fifo_valid,
    input  wire logic [mspe_pkg::LINE_W-1:0]                            recv_fifo_q,
    input  wire logic                                                   frame_sent,
    output logic                                                        recv_fifo_rdreq,
    output logic      [mspe_pkg::NUM_CORES-1:0]                         core_start,
    output logic      [mspe_pkg::NUM_CORES-1:0][mspe_pkg::TUPLE_W-1:0] core_tuple_a,
    output logic      [mspe_pkg::NUM_CORES-1:0][mspe_pkg::TUPLE_W-1:0] core_tuple_b
);

    logic in_flight;
    logic fire;

    // Only one line is worked on at a time
    assign fire = prog_ready && recv_fifo_valid && !in_flight;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight       <= 1'b0;
            recv_fifo_rdreq <= 1'b0;
            core_start      <= '0;
        end else if (all_core_reset) begin
            in_flight       <= 1'b0;
            recv_fifo_rdreq <= 1'b0;
            core_start      <= '0;
        end else begin
            recv_fifo_rdreq <= fire;
            core_start      <= {mspe_pkg::NUM_CORES{fire}};
            if (fire) begin
                in_flight <= 1'b1;
            end else if (frame_sent) begin
                in_flight <= 1'b0;
            end
        end
    end

    // Tuple c goes to core c as tuple a, tuple c+NUM_CORES as tuple b
    always_ff @(posedge clk) begin
        if (fire) begin
            for (int c = 0; c < mspe_pkg::NUM_CORES; c++) begin
                core_tuple_a[c] <= recv_fifo_q[c*mspe_pkg::TUPLE_W +: mspe_pkg::TUPLE_W];
                core_tuple_b[c] <= recv_fifo_q[(c+mspe_pkg::NUM_CORES)*mspe_pkg::TUPLE_W
                                               +: mspe_pkg::TUPLE_W];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/mspe_core.sv
`timescale 1ns/1ps
`default_nettype none

module mspe_core (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           all_core_reset,
    input  wire logic                           prog_we,
    input  wire logic [mspe_pkg::LINE_W-1:0]    prog_line,
    input  wire logic                           start,
    input  wire logic [mspe_pkg::TUPLE_W-1:0]   tuple_a,
    input  wire logic [mspe_pkg::TUPLE_W-1:0]   tuple_b,
    output logic                                done,
    output logic      [mspe_pkg::DATA_W-1:0]    result_a,
    output logic      [mspe_pkg::DATA_W-1:0]    result_b,
    output logic                                busy
);

    logic [mspe_pkg::INSN_W-1:0] prog_mem [mspe_pkg::PROG_DEPTH];
    logic [mspe_pkg::DATA_W-1:0] regs [mspe_pkg::NUM_REGS];
    logic [mspe_pkg::DATA_W-1:0] result;
    logic [mspe_pkg::PC_W-1:0]   pc;
    logic                        sel_b;
    logic                        running;

    mspe_pkg::insn_t             insn;
    logic [mspe_pkg::DATA_W-1:0] rd_val;
    logic [mspe_pkg::DATA_W-1:0] rs_val;
    logic [mspe_pkg::DATA_W-1:0] imm_ext;
    logic [mspe_pkg::DATA_W-1:0] result_next;
    logic                        last;

    assign insn    = prog_mem[pc];
    assign rd_val  = regs[insn.r.rd];
    assign rs_val  = regs[insn.r.rs];
    assign imm_ext = {{(mspe_pkg::DATA_W-mspe_pkg::IMM_W){insn.i.imm[mspe_pkg::IMM_W-1]}},
                      insn.i.imm};

    // The current instruction may itself be the EMIT that ends the tuple
    assign result_next = (insn.r.opcode == mspe_pkg::OP_EMIT) ? rd_val : result;
    assign last        = (insn.r.opcode == mspe_pkg::OP_HALT) ||
                         (pc == mspe_pkg::PC_W'(mspe_pkg::PROG_DEPTH - 1));
    assign busy        = running;

    always_ff @(posedge clk) begin
        if (prog_we) begin
            for (int i = 0; i < mspe_pkg::PROG_DEPTH; i++) begin
                prog_mem[i] <= prog_line[i*mspe_pkg::INSN_W +: mspe_pkg::INSN_W];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            done    <= 1'b0;
            sel_b   <= 1'b0;
            pc      <= '0;
        end else if (all_core_reset) begin
            running <= 1'b0;
            done    <= 1'b0;
            sel_b   <= 1'b0;
            pc      <= '0;
        end else if (start) begin
            running <= 1'b1;
            done    <= 1'b0;
            sel_b   <= 1'b0;
            pc      <= '0;
        end else if (running) begin
            if (!last) begin
                pc <= pc + 1'b1;
            end else if (!sel_b) begin
                sel_b <= 1'b1; // Move on to tuple b
                pc    <= '0;
            end else begin
                running <= 1'b0;
                done    <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            regs[0] <= tuple_a[mspe_pkg::DATA_W-1:0];
            regs[1] <= tuple_a[mspe_pkg::TUPLE_W-1:mspe_pkg::DATA_W];
            regs[2] <= '0;
            regs[3] <= '0;
            result  <= '0;
        end else if (running) begin
            case (insn.r.opcode)
                mspe_pkg::OP_ADD:  regs[insn.r.rd] <= rd_val + rs_val;
                mspe_pkg::OP_SUB:  regs[insn.r.rd] <= rd_val - rs_val;
                mspe_pkg::OP_ADDI: regs[insn.i.rd] <= rd_val + imm_ext;
                default: ;
            endcase
            result <= result_next;
            if (last) begin
                if (sel_b) begin
                    result_b <= result_next;
                end else begin
                    result_a <= result_next;
                    regs[0]  <= tuple_b[mspe_pkg::DATA_W-1:0]; // Fresh state for tuple b
                    regs[1]  <= tuple_b[mspe_pkg::TUPLE_W-1:mspe_pkg::DATA_W];
                    regs[2]  <= '0;
                    regs[3]  <= '0;
                    result   <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/mspe_result_collect.sv
`timescale 1ns/1ps
`default_nettype none

module mspe_result_collect (
    input  wire logic                                                  clk,
    input  wire logic                                                  rst_n,
    input  wire logic                                                  all_core_reset,
    input  wire logic                                                  recv_fifo_rdreq,
    input  wire logic [mspe_pkg::LINE_W-1:0]                           recv_fifo_q,
    input  wire logic [mspe_pkg::NUM_CORES-1:0]                        core_done,
    input  wire logic [mspe_pkg::NUM_CORES-1:0][mspe_pkg::DATA_W-1:0] core_result_a,
    input  wire logic [mspe_pkg::NUM_CORES-1:0][mspe_pkg::DATA_W-1:0] core_result_b,
    input  wire logic                                                  src_ready,
    output logic      [63:0]                                           src_data,
    output logic                                                       src_valid,
    output logic                                                       src_sop,
    output logic                                                       src_eop,
    output logic                                                       frame_sent
);

    logic [mspe_pkg::DATA_W-1:0] key_q [mspe_pkg::TUPLES_PER_LINE];
    logic [mspe_pkg::BEAT_W-1:0] beat;
    logic [mspe_pkg::CORE_W-1:0] core_sel;
    logic [mspe_pkg::DATA_W-1:0] beat_result;
    logic                        all_done;
    logic                        all_done_q;
    logic                        last_beat;

    assign all_done  = &core_done;
    assign last_beat = (beat == mspe_pkg::BEAT_W'(mspe_pkg::TUPLES_PER_LINE - 1));

    // Low beats come from slot a of each core, high beats from slot b
    assign core_sel    = beat[mspe_pkg::CORE_W-1:0];
    assign beat_result = beat[mspe_pkg::BEAT_W-1] ? core_result_b[core_sel]
                                                  : core_result_a[core_sel];

    assign src_data   = {key_q[beat], beat_result};
    assign src_sop    = src_valid && (beat == '0);
    assign src_eop    = src_valid && last_beat;
    assign frame_sent = src_valid && src_ready && last_beat;

    always_ff @(posedge clk) begin
        if (recv_fifo_rdreq) begin
            for (int k = 0; k < mspe_pkg::TUPLES_PER_LINE; k++) begin
                key_q[k] <= recv_fifo_q[k*mspe_pkg::TUPLE_W +: mspe_pkg::DATA_W];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_valid  <= 1'b0;
            beat       <= '0;
            all_done_q <= 1'b0;
        end else if (all_core_reset) begin
            src_valid  <= 1'b0;
            beat       <= '0;
            all_done_q <= 1'b0;
        end else begin
            all_done_q <= all_done;
            if (all_done && !all_done_q) begin
                src_valid <= 1'b1; // Arm once per line
                beat      <= '0;
            end else if (src_valid && src_ready) begin
                if (last_beat) begin
                    src_valid <= 1'b0;
                    beat      <= '0;
                end else begin
                    beat <= beat + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/mspe.sv
`timescale 1ns/1ps
`default_nettype none

module mspe (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             m0_waitrequest,
    input  wire logic [mspe_pkg::LINE_W-1:0]      m0_readdata,
    input  wire logic                             m0_readdatavalid,
    output logic      [63:0]                      m0_address,
    output logic                                  m0_read,
    input  wire logic                             recv_fifo_valid,
    input  wire logic [mspe_pkg::LINE_W-1:0]      recv_fifo_q,
    output logic                                  recv_fifo_rdreq,
    output logic      [63:0]                      src_data,
    output logic                                  src_valid,
    output logic                                  src_sop,
    output logic                                  src_eop,
    input  wire logic                             src_ready,
    output logic      [mspe_pkg::NUM_CORES-1:0]   core_status,
    input  wire logic                             all_core_reset
);

    logic                                                       prog_we;
    logic [mspe_pkg::LINE_W-1:0]                                prog_line;
    logic                                                       prog_ready;
    logic [mspe_pkg::NUM_CORES-1:0]                             core_start;
    logic [mspe_pkg::NUM_CORES-1:0][mspe_pkg::TUPLE_W-1:0]     core_tuple_a;
    logic [mspe_pkg::NUM_CORES-1:0][mspe_pkg::TUPLE_W-1:0]     core_tuple_b;
    logic [mspe_pkg::NUM_CORES-1:0]                             core_done;
    logic [mspe_pkg::NUM_CORES-1:0][mspe_pkg::DATA_W-1:0]      core_result_a;
    logic [mspe_pkg::NUM_CORES-1:0][mspe_pkg::DATA_W-1:0]      core_result_b;
    logic                                                       frame_sent;

    mspe_prog_loader loader_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .all_core_reset   (all_core_reset),
        .m0_waitrequest   (m0_waitrequest),
        .m0_readdata      (m0_readdata),
        .m0_readdatavalid (m0_readdatavalid),
        .m0_address       (m0_address),
        .m0_read          (m0_read),
        .prog_we          (prog_we),
        .prog_line        (prog_line),
        .prog_ready       (prog_ready)
    );

    mspe_tuple_dispatch dispatch_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .all_core_reset  (all_core_reset),
        .prog_ready      (prog_ready),
        .recv_fifo_valid (recv_fifo_valid),
        .recv_fifo_q     (recv_fifo_q),
        .frame_sent      (frame_sent),
        .recv_fifo_rdreq (recv_fifo_rdreq),
        .core_start      (core_start),
        .core_tuple_a    (core_tuple_a),
        .core_tuple_b    (core_tuple_b)
    );

    for (genvar c = 0; c < mspe_pkg::NUM_CORES; c++) begin : g_core
        mspe_core core_inst (
            .clk            (clk),
            .rst_n          (rst_n),
            .all_core_reset (all_core_reset),
            .prog_we        (prog_we),
            .prog_line      (prog_line),
            .start          (core_start[c]),
            .tuple_a        (core_tuple_a[c]),
            .tuple_b        (core_tuple_b[c]),
            .done           (core_done[c]),
            .result_a       (core_result_a[c]),
            .result_b       (core_result_b[c]),
            .busy           (core_status[c])
        );
    end

    mspe_result_collect collect_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .all_core_reset  (all_core_reset),
        .recv_fifo_rdreq (recv_fifo_rdreq),
        .recv_fifo_q     (recv_fifo_q),
        .core_done       (core_done),
        .core_result_a   (core_result_a),
        .core_result_b   (core_result_b),
        .src_ready       (src_ready),
        .src_data        (src_data),
        .src_valid       (src_valid),
        .src_sop         (src_sop),
        .src_eop         (src_eop),
        .frame_sent      (frame_sent)
    );

endmodule

`default_nettype wire

//--- verif/mspe_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module mspe_clk_gen (
    output logic clk
);

    localparam time HALF_PERIOD = 4ns; // 8 ns period

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

//--- verif/mspe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mspe_tb;

    localparam int NUM_TESTS      = 6;
    localparam int CYCLES_PER_TEST = 2000;

    logic clk;
    logic rst_n;
    logic m0_waitrequest;
    logic [511:0] m0_readdata;
    logic m0_readdatavalid;
    logic [63:0] m0_address;
    logic m0_read;
    logic recv_fifo_valid;
    logic [511:0] recv_fifo_q;
    logic recv_fifo_rdreq;
    logic [63:0] src_data;
    logic src_valid;
    logic src_sop;
    logic src_eop;
    logic src_ready;
    logic [3:0] core_status;
    logic all_core_reset;

    logic [511:0] prog;
    logic [511:0] fifo_lines [$];
    logic [63:0] exp_beats [$];
    logic stalls = 1'b0;
    logic random_ready = 1'b0;
    logic prog_loaded = 1'b0;
    logic pending = 1'b0;
    logic stall_q = 1'b0;
    logic busy_seen = 1'b0;
    logic [63:0] held_data;
    int lat;
    int beat_idx = 0;
    int frames = 0;

    mspe_clk_gen clk_gen_inst (.clk(clk));

    mspe mspe_inst (
        .clk(clk), .rst_n(rst_n),
        .m0_waitrequest(m0_waitrequest), .m0_readdata(m0_readdata),
        .m0_readdatavalid(m0_readdatavalid), .m0_address(m0_address), .m0_read(m0_read),
        .recv_fifo_valid(recv_fifo_valid), .recv_fifo_q(recv_fifo_q),
        .recv_fifo_rdreq(recv_fifo_rdreq),
        .src_data(src_data), .src_valid(src_valid), .src_sop(src_sop), .src_eop(src_eop),
        .src_ready(src_ready), .core_status(core_status), .all_core_reset(all_core_reset)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t %s: got %h expected %h", $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] insn(input logic [3:0] op, input logic [1:0] rd,
                                         input logic [1:0] rs, input logic [15:0] imm);
        return {op, rd, rs, 8'h00, imm};
    endfunction

    // Runs one tuple through the whole program by the ISA rules
    function automatic logic [31:0] run_tuple(input logic [511:0] p, input logic [63:0] t);
        logic [31:0] r [4];
        logic [31:0] res;
        logic [31:0] w;
        logic [31:0] imm;
        r[0] = t[31:0];
        r[1] = t[63:32];
        r[2] = '0;
        r[3] = '0;
        res  = '0;
        for (int pc = 0; pc < 16; pc++) begin
            w   = p[pc*32 +: 32];
            imm = {{16{w[15]}}, w[15:0]};
            if (w[31:28] == 4'd5) break;
            case (w[31:28])
                4'd1: r[w[27:26]] = r[w[27:26]] + r[w[25:24]];
                4'd2: r[w[27:26]] = r[w[27:26]] - r[w[25:24]];
                4'd3: r[w[27:26]] = r[w[27:26]] + imm;
                4'd4: res = r[w[27:26]];
                default: ;
            endcase
        end
        return res;
    endfunction

    function automatic logic [511:0] make_prog(input int sel);
        logic [511:0] p;
        p = '0;
        case (sel)
            0: begin // key plus value
                p[0*32 +: 32] = insn(4'd1, 2'd0, 2'd1, 16'h0);
                p[1*32 +: 32] = insn(4'd4, 2'd0, 2'd0, 16'h0);
                p[2*32 +: 32] = insn(4'd5, 2'd0, 2'd0, 16'h0);
            end
            1: begin
                p[0*32 +: 32] = insn(4'd3, 2'd2, 2'd0, 16'hfffb);
                p[1*32 +: 32] = insn(4'd2, 2'd0, 2'd2, 16'h0);
                p[3*32 +: 32] = insn(4'd1, 2'd3, 2'd0, 16'h0);
                p[4*32 +: 32] = insn(4'd3, 2'd3, 2'd0, 16'h7fff);
                p[5*32 +: 32] = insn(4'd4, 2'd3, 2'd0, 16'h0);
                p[6*32 +: 32] = insn(4'd5, 2'd0, 2'd0, 16'h0);
            end
            2: begin // No EMIT at all
                p[0*32 +: 32] = insn(4'd1, 2'd0, 2'd1, 16'h0);
                p[1*32 +: 32] = insn(4'd5, 2'd0, 2'd0, 16'h0);
            end
            3: begin // No HALT and the EMIT sits in the last slot
                for (int i = 0; i < 15; i++) p[i*32 +: 32] = insn(4'd3, 2'd0, 2'd0, 16'h3);
                p[15*32 +: 32] = insn(4'd4, 2'd0, 2'd0, 16'h0);
            end
            default: begin
                p[0*32 +: 32] = insn(4'd2, 2'd1, 2'd0, 16'h0);
                p[1*32 +: 32] = insn(4'd4, 2'd1, 2'd0, 16'h0);
                p[2*32 +: 32] = insn(4'd5, 2'd0, 2'd0, 16'h0);
            end
        endcase
        return p;
    endfunction

    task automatic push_lines(input int n);
        logic [511:0] line;
        @(negedge clk);
        for (int l = 0; l < n; l++) begin
            for (int k = 0; k < 16; k++) line[k*32 +: 32] = $urandom;
            fifo_lines.push_back(line);
            for (int k = 0; k < 8; k++) begin
                exp_beats.push_back({line[k*64 +: 32], run_tuple(prog, line[k*64 +: 64])});
            end
        end
    endtask

    task automatic wait_drain();
        while (exp_beats.size() != 0 || fifo_lines.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    task automatic reload_program(input int sel);
        prog = make_prog(sel);
        @(posedge clk);
        prog_loaded = 1'b0;
        all_core_reset <= 1'b1;
        @(posedge clk);
        all_core_reset <= 1'b0;
    endtask

    // Memory read port with optional stalls and latency
    always @(posedge clk) begin
        if (!rst_n) begin
            pending = 1'b0;
            m0_readdatavalid <= 1'b0;
        end else begin
            m0_readdatavalid <= 1'b0;
            m0_waitrequest <= stalls ? 1'($urandom % 2) : 1'b0;
            if (pending) begin
                if (lat == 0) begin
                    m0_readdata      <= prog;
                    m0_readdatavalid <= 1'b1;
                    pending     = 1'b0;
                    prog_loaded = 1'b1;
                end else begin
                    lat--;
                end
            end else if (m0_read && !m0_waitrequest) begin
                check("m0_address", m0_address, 64'h1000);
                pending = 1'b1;
                lat = stalls ? int'($urandom % 6) : 0;
            end
        end
    end

    // Show-ahead receive FIFO
    always @(posedge clk) begin
        if (recv_fifo_rdreq) void'(fifo_lines.pop_front());
        recv_fifo_valid <= fifo_lines.size() != 0;
        recv_fifo_q     <= fifo_lines.size() != 0 ? fifo_lines[0] : '0;
    end

    always @(posedge clk) begin
        src_ready <= random_ready ? 1'($urandom % 2) : 1'b1;
    end

    // Output monitor
    always @(posedge clk) begin
        if (rst_n) begin
            if (core_status == 4'hf) busy_seen = 1'b1;
            if (src_valid) begin
                check("core_status", 64'(core_status), 64'd0); // Cores idle while streaming
            end
            if (stall_q) begin
                check("src_valid", {63'd0, src_valid}, 64'd1);
                check("src_data", src_data, held_data);
            end
            if ((src_valid || recv_fifo_rdreq) && !prog_loaded) begin
                abort_run("Engine became active before the program was loaded");
            end
            if (src_valid && src_ready) begin
                if (exp_beats.size() == 0) abort_run("Output beat arrived with none expected");
                check("src_data", src_data, exp_beats.pop_front());
                check("src_sop", {63'd0, src_sop}, {63'd0, beat_idx == 0});
                check("src_eop", {63'd0, src_eop}, {63'd0, beat_idx == 7});
                beat_idx = (beat_idx == 7) ? 0 : beat_idx + 1;
                if (src_eop) frames++;
            end
            stall_q   = src_valid && !src_ready;
            held_data = src_data;
        end
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * 8ns);
        abort_run("Timeout waiting for the engine to finish");
    end

    initial begin
        int frames_before;
        void'($urandom(56234));
        rst_n = 1'b0;
        all_core_reset = 1'b0;
        m0_waitrequest = 1'b0;
        m0_readdata = '0;
        m0_readdatavalid = 1'b0;
        recv_fifo_valid = 1'b0;
        recv_fifo_q = '0;
        src_ready = 1'b1;
        prog = make_prog(0);
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        push_lines(1); // Basic program
        wait_drain();
        check("frames", 64'(frames), 64'd1);

        for (int s = 1; s <= 3; s++) begin // Full ISA
            reload_program(s);
            push_lines(2);
            wait_drain();
        end

        frames_before = frames; // Back-to-back lines
        push_lines(5);
        wait_drain();
        check("frames", 64'(frames), 64'(frames_before + 5));

        random_ready = 1'b1; // Back-pressure
        push_lines(3);
        wait_drain();
        random_ready = 1'b0;

        stalls = 1'b1; // Memory stalls
        reload_program(1);
        push_lines(2);
        wait_drain();
        stalls = 1'b0;

        check("core_status", 64'(core_status), 64'd0); // Reload
        busy_seen = 1'b0;
        reload_program(4);
        push_lines(2);
        wait_drain();
        check("core_status", 64'(core_status), 64'd0);
        check("busy_seen", {63'd0, busy_seen}, 64'd1);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
source/mspe_pkg.sv
source/mspe_prog_loader.sv
source/mspe_tuple_dispatch.sv
source/mspe_core.sv
source/mspe_result_collect.sv
source/mspe.sv
verif/mspe_clk_gen.sv
verif/mspe_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mspe_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
